//--- common/imgproc_pkg.sv
////////////////////////////////////////////////////////////
// geometry fixed at 640x480, three ball colours only
// status and message layout match the CPU driver
////////////////////////////////////////////////////////////
package imgproc_pkg;

	// data widths
	typedef logic [23:0] pixel_t;
	typedef logic [7:0]  chan_t;
	typedef logic [10:0] coord_t;
	typedef logic [31:0] msg_word_t;
	typedef logic [7:0]  fifo_count_t;

	// ball colours, index order is also priority order
	typedef enum logic [1:0] {
		BALL_RED    = 2'd0,
		BALL_YELLOW = 2'd1,
		BALL_BLACK  = 2'd2
	} ball_e;
	localparam int NUM_BALLS = 3;

	typedef enum logic [1:0] {
		MSG_IDLE,
		MSG_ID,
		MSG_BOUNDS
	} msg_state_e;

	////////////////////////////////////////////////////////////
	// image geometry
	localparam coord_t IMAGE_W   = 11'd640;
	localparam coord_t IMAGE_H   = 11'd480;
	// bounds only from the lower part of the image
	localparam coord_t ROW_FLOOR = 11'd280;
	// black ignored near the frame edge
	localparam coord_t BORDER    = 11'd10;
	localparam int FILTER_DEPTH  = 4;

	////////////////////////////////////////////////////////////
	// message path
	localparam int MSG_INTERVAL = 6;
	localparam int MSG_BUF_MAX  = 256;
	localparam int MSG_WORDS    = 4;
	// "RBB" in ascii
	localparam msg_word_t MSG_ID_WORD = 32'h0052_4242;
	localparam msg_word_t CORE_ID     = 32'h1234_EEE2;

	// slave port map
	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG    = 3'd1;
	localparam logic [2:0] ADDR_ID     = 3'd2;
	localparam int FLUSH_BIT = 4;

	////////////////////////////////////////////////////////////
	// overlay colours
	localparam pixel_t HL_RED     = 24'hff1000;
	localparam pixel_t HL_YELLOW  = 24'hffff00;
	localparam pixel_t HL_BLACK   = 24'h000000;
	localparam pixel_t BOX_RED    = 24'hff0000;
	localparam pixel_t BOX_YELLOW = 24'hffff00;
	localparam pixel_t BOX_BLACK  = 24'h000000;
	// indexed by ball_e
	localparam pixel_t HL_COLOURS [NUM_BALLS]  = '{HL_RED, HL_YELLOW, HL_BLACK};
	localparam pixel_t BOX_COLOURS [NUM_BALLS] = '{BOX_RED, BOX_YELLOW, BOX_BLACK};

endpackage

//--- common/pixel_stream_if.sv
////////////////////////////////////////////////////////////
// one word moves on a clock with valid and ready both high
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

interface pixel_stream_if
	import imgproc_pkg::*;
();
	pixel_t pixel;
	logic   sop;
	logic   eop;
	logic   valid;
	logic   ready;

	// producer must hold valid until the transfer
	modport producer (output pixel, sop, eop, valid, input ready);
	modport consumer (input pixel, sop, eop, valid, output ready);

endinterface

//--- hdl/stream_reg.sv
////////////////////////////////////////////////////////////
// single-entry stage, one cycle latency, no bubble on full flow
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module stream_reg (
	input logic clk,
	input logic reset_n,
	pixel_stream_if.consumer up,
	pixel_stream_if.producer down
);

	logic full;

	// take a new word when empty or when the held word leaves
	assign up.ready   = down.ready | ~full;
	assign down.valid = full;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			full <= 1'b0;
		end else if (up.ready) begin
			full <= up.valid;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (up.ready && up.valid) begin
			down.pixel <= up.pixel;
			down.sop   <= up.sop;
			down.eop   <= up.eop;
		end
	end

endmodule

//--- pixel/hsv_convert.sv
////////////////////////////////////////////////////////////
// purely combinational with hue in half degrees 0..180
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module hsv_convert
	import imgproc_pkg::*;
(
	input  pixel_t pixel,
	output chan_t  hue,
	output chan_t  sat,
	output chan_t  value
);

	chan_t r, g, b;
	chan_t cmin;
	chan_t delta;
	logic [17:0] num;
	logic [8:0]  deg;
	logic [15:0] spread;

	assign r = pixel[23:16];
	assign g = pixel[15:8];
	assign b = pixel[7:0];

	// value is the largest channel
	assign value = (r >= g) ? ((r >= b) ? r : b) : ((g >= b) ? g : b);
	assign cmin  = (r <= g) ? ((r <= b) ? r : b) : ((g <= b) ? g : b);
	assign delta = value - cmin;

	// sat = spread * 255 / value
	assign spread = {8'd0, delta} * 16'd255;
	assign sat    = (value == 8'd0) ? 8'd0 : chan_t'(spread / {8'd0, value});

	always_comb begin
		// numerator over delta gives degrees
		if (value == r) begin
			// red sector wraps round through 360
			if (g >= b) begin
				num = 18'd60 * (g - b);
			end else begin
				num = 18'd360 * delta - 18'd60 * (b - g);
			end
		end else if (value == g) begin
			num = 18'd120 * delta + 18'd60 * b - 18'd60 * r;
		end else begin
			num = 18'd240 * delta + 18'd60 * r - 18'd60 * g;
		end
		deg = (delta == 8'd0) ? 9'd0 : 9'(num / {10'd0, delta});
	end

	// halve to fit a byte
	assign hue = deg[8:1];

endmodule

//--- pixel/ball_classifier.sv
////////////////////////////////////////////////////////////
// thresholds tuned for the rover camera under lab lighting
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module ball_classifier
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	input  logic accept,
	input  chan_t hue,
	input  chan_t sat,
	input  chan_t value,
	input  coord_t x,
	input  coord_t y,
	output logic [NUM_BALLS-1:0] hit
);

	logic [NUM_BALLS-1:0] det;
	// hist[0] is the previous accepted pixel
	logic [NUM_BALLS-1:0] hist [FILTER_DEPTH-1];
	logic red_hue, red_wide, red_narrow;

	// red hue wraps through 0
	assign red_hue    = (hue >= 8'd150 && hue <= 8'd180) || hue <= 8'd6;
	assign red_wide   = (hue >= 8'd160 && hue <= 8'd180) || hue <= 8'd4;
	assign red_narrow = (hue >= 8'd172 && hue <= 8'd180) || hue <= 8'd6;

	// raw per-pixel rules
	assign det[BALL_RED] = (red_hue && sat > 8'd84 && value > 8'd245)
		|| (hue <= 8'd6 && ((value > 8'd229 && sat > 8'd17 && sat < 8'd155)
			|| (value > 8'd210 && sat > 8'd130)))
		|| (hue >= 8'd160 && hue <= 8'd180 && ((sat >= 8'd76 && value >= 8'd249)
			|| (sat >= 8'd102 && value >= 8'd140)))
		|| (red_wide && sat > 8'd140 && sat <= 8'd179 && value >= 8'd89 && value <= 8'd106)
		|| (red_narrow && ((value > 8'd105 && sat > 8'd102) || (sat > 8'd82 && value > 8'd168)));

	assign det[BALL_YELLOW] = (hue >= 8'd16 && hue <= 8'd25 && sat > 8'd133 && value > 8'd124)
		|| (hue >= 8'd23 && hue <= 8'd30 && ((value > 8'd155 && sat > 8'd127)
			|| (sat >= 8'd153 && value > 8'd252) || (value > 8'd100 && sat > 8'd247)));

	// dark and away from the frame edge
	assign det[BALL_BLACK] = value <= 8'd37 && x > BORDER && x < IMAGE_W - BORDER
		&& y > BORDER && y < IMAGE_H - BORDER;

	// noise filter, every pixel of the run must detect
	always_comb begin
		hit = det;
		for (int i = 0; i < FILTER_DEPTH - 1; i++) begin
			hit = hit & hist[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < FILTER_DEPTH - 1; i++) begin
				hist[i] <= '0;
			end
		end else if (accept) begin
			hist[0] <= det;
			for (int i = 1; i < FILTER_DEPTH - 1; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

endmodule

//--- pixel/frame_tracker.sv
////////////////////////////////////////////////////////////
// empty bound reads left IMAGE_W-1, right 0
// bounds move to left/right only at a video eop
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module frame_tracker
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	input  logic accept,
	input  logic sop,
	input  logic eop,
	input  logic [3:0] sop_tag,
	input  logic [NUM_BALLS-1:0] hit,
	output coord_t x,
	output coord_t y,
	output logic packet_video,
	output coord_t left [NUM_BALLS],
	output coord_t right [NUM_BALLS],
	output logic frame_done
);

	coord_t x_min [NUM_BALLS];
	coord_t x_max [NUM_BALLS];

	assign frame_done = accept & eop & packet_video;

	////////////////////////////////////////////////////////////
	// pixel position, sop word is the packet descriptor
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
		end else if (accept) begin
			if (sop) begin
				x <= '0;
				y <= '0;
				// tag 0 marks video data
				packet_video <= (sop_tag == 4'h0);
			end else if (x == IMAGE_W - 11'd1) begin
				x <= '0;
				y <= y + 11'd1;
			end else begin
				x <= x + 11'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// running column range per colour
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_BALLS; i++) begin
				x_min[i] <= IMAGE_W - 11'd1;
				x_max[i] <= '0;
			end
		end else if (accept) begin
			for (int i = 0; i < NUM_BALLS; i++) begin
				if (sop) begin
					x_min[i] <= IMAGE_W - 11'd1;
					x_max[i] <= '0;
				end else if (hit[i] && y > ROW_FLOOR) begin
					if (x < x_min[i]) x_min[i] <= x;
					if (x > x_max[i]) x_max[i] <= x;
				end
			end
		end
	end

	// hold for overlay and messages of the next frame
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_BALLS; i++) begin
				left[i]  <= IMAGE_W - 11'd1;
				right[i] <= '0;
			end
		end else if (frame_done) begin
			left  <= x_min;
			right <= x_max;
		end
	end

endmodule

//--- pixel/overlay_mux.sv
////////////////////////////////////////////////////////////
// sop word and non-video packets always pass unchanged
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module overlay_mux
	import imgproc_pkg::*;
(
	input  pixel_t pixel_in,
	input  logic [NUM_BALLS-1:0] hit,
	input  coord_t x,
	input  coord_t left [NUM_BALLS],
	input  coord_t right [NUM_BALLS],
	input  logic mode,
	input  logic sop,
	input  logic packet_video,
	output pixel_t pixel_out
);

	chan_t grey;
	pixel_t marked;
	logic on_left, on_right;

	// grey = g/2 + r/4 + b/4
	assign grey = {1'b0, pixel_in[15:9]} + {2'b00, pixel_in[23:18]} + {2'b00, pixel_in[7:2]};

	always_comb begin
		marked = {grey, grey, grey};
		// highlight, lowest index wins
		for (int i = NUM_BALLS - 1; i >= 0; i--) begin
			if (hit[i]) marked = HL_COLOURS[i];
		end
		// bounding columns draw over highlights
		for (int i = NUM_BALLS - 1; i >= 0; i--) begin
			on_left  = (x == left[i]) && (left[i] != IMAGE_W - 11'd1);
			on_right = (x == right[i]) && (right[i] != 11'd0);
			if (on_left || on_right) marked = BOX_COLOURS[i];
		end
	end

	assign pixel_out = (mode && !sop && packet_video) ? marked : pixel_in;

endmodule

//--- hdl/msg_writer.sv
////////////////////////////////////////////////////////////
// one message per MSG_INTERVAL video frames, skipped if FIFO short of room
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module msg_writer
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	input  logic frame_done,
	input  coord_t left [NUM_BALLS],
	input  coord_t right [NUM_BALLS],
	input  fifo_count_t fifo_count,
	output logic wr,
	output msg_word_t wr_data
);

	msg_state_e state;
	logic [1:0] ball_idx;
	logic [2:0] frame_count;
	logic room;
	logic start;

	assign room  = fifo_count < fifo_count_t'(MSG_BUF_MAX - MSG_WORDS);
	assign start = frame_done && frame_count == 3'd0 && room && state == MSG_IDLE;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state       <= MSG_IDLE;
			ball_idx    <= '0;
			frame_count <= '0;
		end else begin
			// interval counter, held at zero while the FIFO is short
			if (start) begin
				frame_count <= 3'(MSG_INTERVAL - 1);
			end else if (frame_done && frame_count != 3'd0) begin
				frame_count <= frame_count - 3'd1;
			end
			case (state)
				MSG_IDLE: if (start) state <= MSG_ID;
				MSG_ID: begin
					state    <= MSG_BOUNDS;
					ball_idx <= '0;
				end
				MSG_BOUNDS: begin
					if (ball_idx == 2'(NUM_BALLS - 1)) state <= MSG_IDLE;
					else ball_idx <= ball_idx + 2'd1;
				end
				default: state <= MSG_IDLE;
			endcase
		end
	end

	// word per state, bounds in ball_e order
	always_comb begin
		wr = (state != MSG_IDLE);
		case (state)
			MSG_ID:     wr_data = MSG_ID_WORD;
			MSG_BOUNDS: wr_data = {5'd0, left[ball_idx], 5'd0, right[ball_idx]};
			default:    wr_data = '0;
		endcase
	end

endmodule

//--- hdl/msg_fifo.sv
////////////////////////////////////////////////////////////
// fall-through head; writes when full and reads when empty are dropped
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module msg_fifo
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	input  logic flush,
	input  logic wr,
	input  msg_word_t wr_data,
	input  logic rd,
	output msg_word_t rd_data,
	output fifo_count_t count,
	output logic empty
);

	msg_word_t mem [MSG_BUF_MAX];
	logic [$clog2(MSG_BUF_MAX)-1:0] wr_ptr, rd_ptr;
	// one bit wider than count so full differs from empty
	logic [$clog2(MSG_BUF_MAX):0] fill;
	logic do_wr, do_rd;

	assign empty   = (fill == '0);
	assign count   = fill[$clog2(MSG_BUF_MAX)-1:0];
	assign do_wr   = wr && (fill != ($clog2(MSG_BUF_MAX) + 1)'(MSG_BUF_MAX));
	assign do_rd   = rd && !empty;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
	end

	// pointers and fill, cleared by reset or flush
	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd) fill <= fill + 1'b1;
			else if (do_rd && !do_wr) fill <= fill - 1'b1;
		end
	end

endmodule

//--- hdl/mm_regs.sv
////////////////////////////////////////////////////////////
// read data one cycle after the strobe; flush bit reads back 0
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module mm_regs
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	input  logic chipselect,
	input  logic read,
	input  logic write,
	input  logic [2:0] address,
	input  msg_word_t writedata,
	output msg_word_t readdata,
	input  fifo_count_t fifo_count,
	input  msg_word_t fifo_data,
	input  logic fifo_empty,
	output logic pop,
	output logic flush
);

	logic [7:0] reg_status;
	// previous read, so a held read pops only once
	logic read_d;

	assign flush = chipselect & write & (address == ADDR_STATUS) & writedata[FLUSH_BIT];
	assign pop   = chipselect & read & ~read_d & ~fifo_empty & (address == ADDR_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= '0;
		end else if (chipselect && write && address == ADDR_STATUS) begin
			reg_status <= writedata[7:0];
			reg_status[FLUSH_BIT] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
			read_d   <= 1'b0;
		end else begin
			read_d <= read;
			if (chipselect && read) begin
				case (address)
					// count in 15:8, status in 7:0
					ADDR_STATUS: readdata <= {16'd0, fifo_count, reg_status};
					ADDR_MSG:    readdata <= fifo_data;
					ADDR_ID:     readdata <= CORE_ID;
					default:     readdata <= '0;
				endcase
			end
		end
	end

endmodule

//--- hdl/eee_imgproc.sv
////////////////////////////////////////////////////////////
// ball detector top, mode high enables the overlay
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module eee_imgproc
	import imgproc_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	// slave port
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  msg_word_t s_writedata,
	output msg_word_t s_readdata,
	// stream in
	input  pixel_t sink_data,
	input  logic sink_valid,
	input  logic sink_sop,
	input  logic sink_eop,
	output logic sink_ready,
	// stream out
	output pixel_t source_data,
	output logic source_valid,
	output logic source_sop,
	output logic source_eop,
	input  logic source_ready,
	input  logic mode
);

	pixel_stream_if sink_if ();
	pixel_stream_if pix_if ();
	pixel_stream_if out_if ();
	pixel_stream_if src_if ();

	chan_t hue, sat, value;
	coord_t x, y;
	coord_t left [NUM_BALLS];
	coord_t right [NUM_BALLS];
	logic [NUM_BALLS-1:0] hit;
	logic accept, packet_video, frame_done;
	logic fifo_wr, fifo_rd, fifo_flush, fifo_empty;
	msg_word_t fifo_wr_data, fifo_rd_data;
	fifo_count_t fifo_count;

	////////////////////////////////////////////////////////////
	// stream ports
	assign sink_if.pixel = sink_data;
	assign sink_if.sop   = sink_sop;
	assign sink_if.eop   = sink_eop;
	assign sink_if.valid = sink_valid;
	assign sink_ready    = sink_if.ready;
	assign source_data   = src_if.pixel;
	assign source_sop    = src_if.sop;
	assign source_eop    = src_if.eop;
	assign source_valid  = src_if.valid;
	assign src_if.ready  = source_ready;

	// pixel path is combinational between the two stages
	assign pix_if.ready = out_if.ready;
	assign out_if.valid = pix_if.valid;
	assign out_if.sop   = pix_if.sop;
	assign out_if.eop   = pix_if.eop;
	assign accept       = pix_if.valid & pix_if.ready;

	stream_reg in_reg (.clk, .reset_n, .up(sink_if.consumer), .down(pix_if.producer));
	stream_reg out_reg (.clk, .reset_n, .up(out_if.consumer), .down(src_if.producer));

	hsv_convert u_hsv (.pixel(pix_if.pixel), .hue, .sat, .value);

	ball_classifier u_classifier (
		.clk, .reset_n, .accept, .hue, .sat, .value, .x, .y, .hit
	);

	// blue low nibble of the sop word is the packet tag
	frame_tracker u_tracker (
		.clk, .reset_n, .accept, .sop(pix_if.sop), .eop(pix_if.eop),
		.sop_tag(pix_if.pixel[3:0]), .hit, .x, .y, .packet_video,
		.left, .right, .frame_done
	);

	overlay_mux u_overlay (
		.pixel_in(pix_if.pixel), .hit, .x, .left, .right, .mode,
		.sop(pix_if.sop), .packet_video, .pixel_out(out_if.pixel)
	);

	////////////////////////////////////////////////////////////
	// message path
	msg_writer u_writer (
		.clk, .reset_n, .frame_done, .left, .right, .fifo_count,
		.wr(fifo_wr), .wr_data(fifo_wr_data)
	);

	msg_fifo u_fifo (
		.clk, .reset_n, .flush(fifo_flush), .wr(fifo_wr), .wr_data(fifo_wr_data),
		.rd(fifo_rd), .rd_data(fifo_rd_data), .count(fifo_count), .empty(fifo_empty)
	);

	mm_regs u_regs (
		.clk, .reset_n, .chipselect(s_chipselect), .read(s_read), .write(s_write),
		.address(s_address), .writedata(s_writedata), .readdata(s_readdata),
		.fifo_count, .fifo_data(fifo_rd_data), .fifo_empty,
		.pop(fifo_rd), .flush(fifo_flush)
	);

endmodule

//--- sim/tb_imgproc.sv
////////////////////////////////////////////////////////////
// full 640x480 frames take a few million clock cycles
// the run stops at the first mismatch
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_imgproc
	import imgproc_pkg::*;
();

	// stimulus picture
	localparam pixel_t BACKGROUND = 24'h808080;
	localparam pixel_t PURE_RED   = 24'hff0000;
	localparam int RUN_COL_FIRST  = 100;
	localparam int RUN_COL_LAST   = 199;
	localparam int RUN_ROW_FIRST  = 300;
	localparam int RUN_ROW_LAST   = 305;
	localparam int STUB_COLS      = 8;
	localparam int OTHER_LEN      = 32;
	localparam logic [3:0] OTHER_TAG = 4'h9;
	// status bits written along with the flush bit
	localparam logic [7:0] STATUS_BITS = 8'ha3;
	// cycle limits for every wait loop
	localparam int WORD_TIMEOUT  = 1000;
	localparam int DRAIN_TIMEOUT = 1000;

	logic clk;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [2:0] s_address;
	msg_word_t s_writedata;
	msg_word_t s_readdata;
	pixel_t sink_data;
	logic sink_valid;
	logic sink_sop;
	logic sink_eop;
	logic sink_ready;
	pixel_t source_data;
	logic source_valid;
	logic source_sop;
	logic source_eop;
	logic source_ready;
	logic mode;

	// scoreboard holds {sop, eop, pixel} per word
	logic [25:0] exp_q [$];
	msg_word_t msg_q [$];

	// reference model state
	coord_t model_x;
	coord_t model_y;
	logic model_video;
	int red_run;
	coord_t run_min [NUM_BALLS];
	coord_t run_max [NUM_BALLS];
	coord_t model_left [NUM_BALLS];
	coord_t model_right [NUM_BALLS];
	logic [7:0] status_model;
	int msg_wait;
	logic msg_added;
	int seed = 4325;

	eee_imgproc u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// random back-pressure with ready about three cycles in four
	initial begin
		source_ready <= 1'b0;
		forever begin
			@(posedge clk);
			source_ready <= ($random(seed) & 3) != 0;
		end
	end

	////////////////////////////////////////////////////////////
	// failure reporting
	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic wrong_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
		abort_run();
	endtask

	task automatic plain_error(input string what);
		$display("%s", what);
		abort_run();
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	function automatic pixel_t grey_of(input pixel_t p);
		chan_t g;
		// green/2 + red/4 + blue/4
		g = (p[15:8] >> 1) + (p[23:16] >> 2) + (p[7:0] >> 2);
		return {g, g, g};
	endfunction

	task automatic predict(input pixel_t d, input logic sop, input logic eop,
		output pixel_t expected);
		logic hit_red;
		logic boxed;
		logic on_left;
		logic on_right;
		// only pure red detects in this stimulus
		red_run = (d == PURE_RED) ? red_run + 1 : 0;
		hit_red = (red_run >= FILTER_DEPTH);
		expected = d;
		if (sop) begin
			// tag 0 in the descriptor word marks video
			model_video = (d[3:0] == 4'h0);
			model_x = '0;
			model_y = '0;
			for (int i = 0; i < NUM_BALLS; i++) begin
				run_min[i] = IMAGE_W - 11'd1;
				run_max[i] = '0;
			end
		end else begin
			if (mode && model_video) begin
				expected = grey_of(d);
				if (hit_red) begin
					expected = HL_RED;
				end
				boxed = 1'b0;
				// lowest colour index wins and empty bounds are not drawn
				for (int i = 0; i < NUM_BALLS; i++) begin
					on_left  = model_x == model_left[i] && model_left[i] != IMAGE_W - 11'd1;
					on_right = model_x == model_right[i] && model_right[i] != 11'd0;
					if (!boxed && (on_left || on_right)) begin
						expected = BOX_COLOURS[i];
						boxed = 1'b1;
					end
				end
			end
			if (hit_red && model_y > ROW_FLOOR) begin
				if (model_x < run_min[BALL_RED]) run_min[BALL_RED] = model_x;
				if (model_x > run_max[BALL_RED]) run_max[BALL_RED] = model_x;
			end
			// bounds govern the next frame
			if (eop && model_video) begin
				model_left  = run_min;
				model_right = run_max;
			end
			if (model_x == IMAGE_W - 11'd1) begin
				model_x = '0;
				model_y = model_y + 11'd1;
			end else begin
				model_x = model_x + 11'd1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// stream side
	task automatic send_word(input pixel_t d, input logic sop, input logic eop);
		int cycles;
		pixel_t expected;
		predict(d, sop, eop, expected);
		exp_q.push_back({sop, eop, expected});
		sink_data  <= d;
		sink_sop   <= sop;
		sink_eop   <= eop;
		sink_valid <= 1'b1;
		cycles = 0;
		// handshake inputs are stable at the falling edge
		@(negedge clk);
		while (!sink_ready) begin
			cycles++;
			if (cycles > WORD_TIMEOUT) begin
				plain_error("sink_ready stayed low, input word never accepted");
			end
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic send_packet(input logic [3:0] tag, input int rows, input int cols,
		input logic random_data);
		pixel_t d;
		logic in_run;
		send_word({20'd0, tag}, 1'b1, 1'b0);
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < cols; c++) begin
				in_run = r >= RUN_ROW_FIRST && r <= RUN_ROW_LAST
					&& c >= RUN_COL_FIRST && c <= RUN_COL_LAST;
				if (random_data) d = pixel_t'($random(seed));
				else if (in_run) d = PURE_RED;
				else d = BACKGROUND;
				send_word(d, 1'b0, r == rows - 1 && c == cols - 1);
			end
		end
		sink_valid <= 1'b0;
		sink_sop   <= 1'b0;
		sink_eop   <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > DRAIN_TIMEOUT) begin
				plain_error("output stream stalled, expected words never left the DUT");
			end
		end
	endtask

	// output checker
	initial begin
		logic [25:0] expected;
		forever begin
			@(negedge clk);
			if (source_valid && source_ready) begin
				if (exp_q.size() == 0) begin
					plain_error("output word arrived while none was expected");
				end else begin
					expected = exp_q.pop_front();
					assert (source_data == expected[23:0]) else
						wrong_value("source_data", {8'd0, source_data}, {8'd0, expected[23:0]});
					assert (source_sop == expected[25]) else
						wrong_value("source_sop", {31'd0, source_sop}, {31'd0, expected[25]});
					assert (source_eop == expected[24]) else
						wrong_value("source_eop", {31'd0, source_eop}, {31'd0, expected[24]});
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// slave port
	task automatic bus_read(input logic [2:0] addr, output msg_word_t data);
		s_chipselect <= 1'b1;
		s_read       <= 1'b1;
		s_address    <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read       <= 1'b0;
		// registered read data
		@(negedge clk);
		data = s_readdata;
		@(posedge clk);
	endtask

	task automatic bus_write(input logic [2:0] addr, input msg_word_t data);
		s_chipselect <= 1'b1;
		s_write      <= 1'b1;
		s_address    <= addr;
		s_writedata  <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write      <= 1'b0;
		@(posedge clk);
	endtask

	task automatic check_count();
		msg_word_t status;
		bus_read(ADDR_STATUS, status);
		assert (status[15:8] == fifo_count_t'(msg_q.size())) else
			wrong_value("s_readdata[15:8]", {24'd0, status[15:8]}, 32'(msg_q.size()));
		assert (status[7:0] == status_model) else
			wrong_value("s_readdata[7:0]", {24'd0, status[7:0]}, {24'd0, status_model});
	endtask

	task automatic read_messages();
		msg_word_t word;
		msg_word_t expected;
		while (msg_q.size() != 0) begin
			expected = msg_q.pop_front();
			bus_read(ADDR_MSG, word);
			assert (word == expected) else wrong_value("s_readdata", word, expected);
		end
	endtask

	// one message per interval when the FIFO has room
	task automatic end_of_frame();
		msg_added = 1'b0;
		if (msg_wait == 0 && msg_q.size() < MSG_BUF_MAX - MSG_WORDS) begin
			msg_q.push_back(MSG_ID_WORD);
			for (int i = 0; i < NUM_BALLS; i++) begin
				msg_q.push_back({5'd0, model_left[i], 5'd0, model_right[i]});
			end
			msg_wait = MSG_INTERVAL - 1;
			msg_added = 1'b1;
		end else if (msg_wait != 0) begin
			msg_wait--;
		end
		// writer is done four cycles after frame end
		repeat (MSG_WORDS + 4) @(posedge clk);
		check_count();
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		msg_word_t rdata;
		reset_n      <= 1'b0;
		mode         <= 1'b0;
		sink_data    <= '0;
		sink_valid   <= 1'b0;
		sink_sop     <= 1'b0;
		sink_eop     <= 1'b0;
		s_chipselect <= 1'b0;
		s_read       <= 1'b0;
		s_write      <= 1'b0;
		s_address    <= '0;
		s_writedata  <= '0;
		model_x = '0;
		model_y = '0;
		model_video = 1'b0;
		red_run = 0;
		status_model = '0;
		msg_wait = 0;
		msg_added = 1'b0;
		for (int i = 0; i < NUM_BALLS; i++) begin
			model_left[i]  = IMAGE_W - 11'd1;
			model_right[i] = '0;
		end
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		// frame 1 with overlay on and no bounds yet
		mode <= 1'b1;
		@(posedge clk);
		send_packet(4'h0, IMAGE_H, IMAGE_W, 1'b0);
		wait_drain();
		end_of_frame();
		// first message read back before the empty count and ID
		read_messages();
		check_count();
		bus_read(ADDR_ID, rdata);
		assert (rdata == CORE_ID) else wrong_value("s_readdata", rdata, CORE_ID);

		// frame 2 draws last frame's columns and adds no message
		send_packet(4'h0, IMAGE_H, IMAGE_W, 1'b0);
		wait_drain();
		end_of_frame();

		// frame 3 straight through
		mode <= 1'b0;
		@(posedge clk);
		send_packet(4'h0, IMAGE_H, IMAGE_W, 1'b0);
		wait_drain();
		end_of_frame();

		// non-video packet bypasses overlay
		mode <= 1'b1;
		@(posedge clk);
		send_packet(OTHER_TAG, 1, OTHER_LEN, 1'b1);
		wait_drain();

		// short video packets run out the interval
		for (int f = 0; f < MSG_INTERVAL && !msg_added; f++) begin
			send_packet(4'h0, 1, STUB_COLS, 1'b0);
			wait_drain();
			end_of_frame();
		end

		// flush clears the pending message and the flush bit reads back 0
		bus_write(ADDR_STATUS, {24'd0, STATUS_BITS} | (msg_word_t'(1) << FLUSH_BIT));
		status_model = STATUS_BITS;
		msg_q.delete();
		check_count();

		$display("Verification passed");
		$finish;
	end

endmodule

//--- sim.f
common/imgproc_pkg.sv
common/pixel_stream_if.sv
hdl/stream_reg.sv
pixel/hsv_convert.sv
pixel/ball_classifier.sv
pixel/frame_tracker.sv
pixel/overlay_mux.sv
hdl/msg_writer.sv
hdl/msg_fifo.sv
hdl/mm_regs.sv
hdl/eee_imgproc.sv
sim/tb_imgproc.sv

//--- run_sim.sh
#!/bin/sh
# build the ball detector testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_imgproc -f sim.f -o tb_imgproc
./obj_dir/tb_imgproc
